//--- hw/dsp_pkg.sv
// Shared definitions for the DSP16-style DAU slice.
// Holds the opcode encoding, instruction field layout, datapath
// widths and the saturation limits used by the store path.

package dsp_pkg;

    // Instruction word layout
    localparam int INSTR_W     = 16;
    localparam int OP_W        = 4;
    localparam int OP_LSB      = 12;
    localparam int ACC_SEL_BIT = 11;
    localparam int IMM_W       = 11;

    // Datapath widths
    localparam int DATA_W = 16;
    localparam int PROD_W = 32;
    localparam int ACC_W  = 36;

    // High-half store limits
    localparam logic [DATA_W-1:0] SAT_POS = 16'h7FFF;
    localparam logic [DATA_W-1:0] SAT_NEG = 16'h8000;

    // Opcodes in bits 15..12
    // Codes above OP_STL are illegal
    typedef enum logic [OP_W-1:0] {
        // No operation
        OP_NOP = 4'd0,
        // x <= sign-extended immediate
        OP_LDX = 4'd1,
        // y <= sign-extended immediate
        OP_LDY = 4'd2,
        // p <= x * y, signed
        OP_MPY = 4'd3,
        // acc <= p, sign-extended
        OP_LDP = 4'd4,
        // acc <= acc + p
        OP_MAC = 4'd5,
        // acc <= acc - p
        OP_MSU = 4'd6,
        // acc <= 0
        OP_CLR = 4'd7,
        // acc <= acc << 16
        OP_SHL = 4'd8,
        // Store acc bits 31..16, saturated
        OP_STH = 4'd9,
        // Store acc bits 15..0
        OP_STL = 4'd10
    } dsp_op_e;

endpackage

//--- hw/dsp_if.sv
// Stage-to-stage buses of the DAU slice.
// dsp_dec_if carries decoded instructions into the DAU, and
// dsp_res_if carries store requests from the DAU to the result stage.

`timescale 1ns/1ns

interface dsp_dec_if;
    import dsp_pkg::*;

    logic              valid;
    dsp_op_e           op;
    logic              acc_sel;
    // Already sign-extended
    logic [DATA_W-1:0] imm;

    modport decode  (output valid, op, acc_sel, imm);
    modport execute (input  valid, op, acc_sel, imm);
endinterface

interface dsp_res_if;
    import dsp_pkg::*;

    logic             valid;
    // Set for a high-half store
    logic             high;
    logic [ACC_W-1:0] acc;

    modport execute (output valid, high, acc);
    modport result  (input  valid, high, acc);
endinterface

//--- hw/dsp_decode.sv
// Instruction decode stage.
// Registers each accepted word, splits it into opcode, accumulator
// select and immediate, and flags illegal opcodes with a sticky fault.

`timescale 1ns/1ns

module dsp_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        instr_valid,
    input  logic [dsp_pkg::INSTR_W-1:0] instr,
    dsp_dec_if.decode                   dec,
    output logic                        fault
);
    import dsp_pkg::*;

    logic [OP_W-1:0]   op_raw;
    logic              illegal;
    logic [DATA_W-1:0] imm_ext;
    logic              accept;

    assign op_raw  = instr[OP_LSB +: OP_W];
    assign illegal = (op_raw > OP_STL);
    assign accept  = cen && instr_valid;

    // Immediate field is two's complement
    assign imm_ext = {{(DATA_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};

    // Decoded word, one strobe per accepted instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec.valid   <= 1'b0;
            dec.op      <= OP_NOP;
            dec.acc_sel <= 1'b0;
            dec.imm     <= '0;
        end else if (cen) begin
            dec.valid <= instr_valid;
            if (instr_valid) begin
                // Illegal codes continue down the pipe as a no-op
                if (illegal) begin
                    dec.op <= OP_NOP;
                end else begin
                    dec.op <= dsp_op_e'(op_raw);
                end
                dec.acc_sel <= instr[ACC_SEL_BIT];
                dec.imm     <= imm_ext;
            end
        end
    end

    // Sticky until the next reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (accept && illegal) begin
            fault <= 1'b1;
        end
    end

endmodule

//--- hw/dsp_dau.sv
// Data arithmetic unit, the execute stage.
// Holds x, y, the product register p and accumulators a0 and a1.
// Each valid decoded word updates these registers on the next
// enabled edge; stores hand the selected accumulator to the result stage.

`timescale 1ns/1ns

module dsp_dau (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    dsp_dec_if.execute dec,
    dsp_res_if.execute res
);
    import dsp_pkg::*;

    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] y;
    logic [PROD_W-1:0] p;
    logic [ACC_W-1:0]  a0;
    logic [ACC_W-1:0]  a1;

    logic [ACC_W-1:0]  acc_cur;
    logic [ACC_W-1:0]  acc_nxt;
    logic [ACC_W-1:0]  p_ext;
    logic              acc_we;
    logic              is_store;
    logic              run;

    assign run      = cen && dec.valid;
    assign acc_cur  = dec.acc_sel ? a1 : a0;
    assign p_ext    = {{(ACC_W-PROD_W){p[PROD_W-1]}}, p};
    assign is_store = (dec.op == OP_STH) || (dec.op == OP_STL);

    // Next value of the selected accumulator, wraps at 36 bits
    always_comb begin
        acc_nxt = acc_cur;
        acc_we  = 1'b1;
        case (dec.op)
            OP_LDP:  acc_nxt = p_ext;
            OP_MAC:  acc_nxt = acc_cur + p_ext;
            OP_MSU:  acc_nxt = acc_cur - p_ext;
            OP_CLR:  acc_nxt = '0;
            OP_SHL:  acc_nxt = {acc_cur[ACC_W-17:0], 16'h0000};
            default: acc_we  = 1'b0;
        endcase
    end

    // Operand and product registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
            p <= '0;
        end else if (run) begin
            case (dec.op)
                OP_LDX:  x <= dec.imm;
                OP_LDY:  y <= dec.imm;
                OP_MPY:  p <= $signed(x) * $signed(y);
                default: ;
            endcase
        end
    end

    // Accumulators
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a0 <= '0;
            a1 <= '0;
        end else if (run && acc_we) begin
            if (dec.acc_sel) begin
                a1 <= acc_nxt;
            end else begin
                a0 <= acc_nxt;
            end
        end
    end

    // Store request, acc sampled before this word's own update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
            res.high  <= 1'b0;
            res.acc   <= '0;
        end else if (cen) begin
            res.valid <= dec.valid && is_store;
            if (dec.valid && is_store) begin
                res.high <= (dec.op == OP_STH);
                res.acc  <= acc_cur;
            end
        end
    end

endmodule

//--- hw/dsp_result.sv
// Result stage of the store path.
// Picks the requested accumulator half and registers it on the output
// port. High-half stores saturate when the accumulator exceeds 32 bits.

`timescale 1ns/1ns

module dsp_result (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,
    dsp_res_if.result                  res,
    output logic                       out_valid,
    output logic [dsp_pkg::DATA_W-1:0] out_data,
    output logic                       out_sat
);
    import dsp_pkg::*;

    logic              ovf;
    logic [DATA_W-1:0] hi_data;

    // Guard bits 35..31 must all match the sign for a 32-bit value
    assign ovf = !((&res.acc[ACC_W-1:PROD_W-1]) || (~|res.acc[ACC_W-1:PROD_W-1]));

    always_comb begin
        if (!ovf) begin
            hi_data = res.acc[PROD_W-1:DATA_W];
        end else if (res.acc[ACC_W-1]) begin
            hi_data = SAT_NEG;
        end else begin
            hi_data = SAT_POS;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            out_sat   <= 1'b0;
        end else if (cen) begin
            out_valid <= res.valid;
            if (res.valid) begin
                out_data <= res.high ? hi_data : res.acc[DATA_W-1:0];
                out_sat  <= res.high && ovf;
            end
        end
    end

endmodule

//--- hw/dsp_core.sv
// Top level of the DAU slice.
// Instruction words enter as a one-cycle strobe and stores leave the
// same way, two enabled edges after acceptance. State moves only when cen is high.

`timescale 1ns/1ns

module dsp_core (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        instr_valid,
    input  logic [dsp_pkg::INSTR_W-1:0] instr,
    output logic                        out_valid,
    output logic [dsp_pkg::DATA_W-1:0]  out_data,
    output logic                        out_sat,
    output logic                        fault
);

    dsp_dec_if dec_bus ();
    dsp_res_if res_bus ();

    dsp_decode u_decode (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cen         ( cen         ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .dec         ( dec_bus     ),
        .fault       ( fault       )
    );

    dsp_dau u_dau (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .cen   ( cen     ),
        .dec   ( dec_bus ),
        .res   ( res_bus )
    );

    dsp_result u_result (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen       ( cen       ),
        .res       ( res_bus   ),
        .out_valid ( out_valid ),
        .out_data  ( out_data  ),
        .out_sat   ( out_sat   )
    );

endmodule

//--- tests/tb_dsp_core.sv
// Testbench for the DAU slice top level.
// Applies a table of instruction words with expected store results and
// fault state, and checks each out_valid strobe as it arrives.

`timescale 1ns/1ns

module tb_dsp_core;
    import dsp_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int PACE_HIGH  = 0;
    localparam int PACE_GAPS  = 1;
    localparam int PACE_BURST = 2;
    localparam int DRAIN_MAX  = 20;

    typedef struct {
        int                 test;
        bit                 rst;
        int                 pace;
        logic [INSTR_W-1:0] instr;
        bit                 store;
        logic [DATA_W-1:0]  data;
        bit                 sat;
        bit                 fault;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               cen;
    logic               instr_valid;
    logic [INSTR_W-1:0] instr;
    logic               out_valid;
    logic [DATA_W-1:0]  out_data;
    logic               out_sat;
    logic               fault;

    row_t              rows[$];
    logic [DATA_W-1:0] exp_data_q[$];
    logic              exp_sat_q[$];
    int                exp_edge_q[$];
    int                edge_cnt;
    int                last_out_edge;
    int                table_len;
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;

    dsp_core i_dut (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cen         ( cen         ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .out_valid   ( out_valid   ),
        .out_data    ( out_data    ),
        .out_sat     ( out_sat     ),
        .fault       ( fault       )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Enabled edges seen so far
    always @(posedge clk) begin
        if (cen) begin
            edge_cnt = edge_cnt + 1;
        end
    end

    // A strobe held over cen-low cycles is one result
    always @(negedge clk) begin
        if (out_valid && edge_cnt != last_out_edge) begin
            last_out_edge = edge_cnt;
            check_output();
        end
    end

    function automatic logic [INSTR_W-1:0] make_instr(input logic [3:0] op, input logic sel,
                                                      input int imm);
        logic [IMM_W-1:0] field;
        field = imm[IMM_W-1:0];
        return {op, sel, field};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "load and multiply";
            2:       return "two accumulators";
            3:       return "high-half saturation";
            4:       return "cen stalls";
            5:       return "illegal opcode";
            6:       return "back-to-back stores";
            default: return "unknown";
        endcase
    endfunction

    task automatic add_op(input int test, input bit rst, input int pace,
                          input logic [INSTR_W-1:0] word, input bit flt);
        rows.push_back(row_t'{test, rst, pace, word, 1'b0, 16'h0000, 1'b0, flt});
    endtask

    task automatic add_store(input int test, input int pace, input logic [INSTR_W-1:0] word,
                             input logic [DATA_W-1:0] data, input bit sat, input bit flt);
        rows.push_back(row_t'{test, 1'b0, pace, word, 1'b1, data, sat, flt});
    endtask

    // a0 = 3 * 1000000 and a1 = -1000000
    task automatic mac_program(input int test, input int pace);
        add_op(test, 1'b1, pace, make_instr(OP_LDX, 1'b0, 1000), 1'b0);
        add_op(test, 1'b0, pace, make_instr(OP_LDY, 1'b0, 1000), 1'b0);
        add_op(test, 1'b0, pace, make_instr(OP_MPY, 1'b0, 0), 1'b0);
        repeat (3)
            add_op(test, 1'b0, pace, make_instr(OP_MAC, 1'b0, 0), 1'b0);
        add_op(test, 1'b0, pace, make_instr(OP_MSU, 1'b1, 0), 1'b0);
        add_store(test, pace, make_instr(OP_STH, 1'b0, 0), 16'h002D, 1'b0, 1'b0);
        add_store(test, pace, make_instr(OP_STL, 1'b0, 0), 16'hC6C0, 1'b0, 1'b0);
        add_store(test, pace, make_instr(OP_STH, 1'b1, 0), 16'hFFF0, 1'b0, 1'b0);
        add_store(test, pace, make_instr(OP_STL, 1'b1, 0), 16'hBDC0, 1'b0, 1'b0);
    endtask

    // p = 1000 * y shifted up 16 past the 32-bit range
    task automatic sat_program(input int y, input logic [DATA_W-1:0] exp_hi);
        add_op(3, 1'b1, PACE_HIGH, make_instr(OP_LDX, 1'b0, 1000), 1'b0);
        add_op(3, 1'b0, PACE_HIGH, make_instr(OP_LDY, 1'b0, y), 1'b0);
        add_op(3, 1'b0, PACE_HIGH, make_instr(OP_MPY, 1'b0, 0), 1'b0);
        add_op(3, 1'b0, PACE_HIGH, make_instr(OP_LDP, 1'b0, 0), 1'b0);
        add_op(3, 1'b0, PACE_HIGH, make_instr(OP_SHL, 1'b0, 0), 1'b0);
        add_store(3, PACE_HIGH, make_instr(OP_STH, 1'b0, 0), exp_hi, 1'b1, 1'b0);
        add_store(3, PACE_HIGH, make_instr(OP_STL, 1'b0, 0), 16'h0000, 1'b0, 1'b0);
    endtask

    // a0 = 300 * -7 = -2100 for the tests that reuse it
    task automatic load_product(input int test);
        add_op(test, 1'b1, PACE_HIGH, make_instr(OP_LDX, 1'b0, 300), 1'b0);
        add_op(test, 1'b0, PACE_HIGH, make_instr(OP_LDY, 1'b0, -7), 1'b0);
        add_op(test, 1'b0, PACE_HIGH, make_instr(OP_MPY, 1'b0, 0), 1'b0);
        add_op(test, 1'b0, PACE_HIGH, make_instr(OP_LDP, 1'b0, 0), 1'b0);
    endtask

    task automatic build_table();
        load_product(1);
        add_store(1, PACE_HIGH, make_instr(OP_STL, 1'b0, 0), 16'hF7CC, 1'b0, 1'b0);
        mac_program(2, PACE_HIGH);
        sat_program(100, 16'h7FFF);
        sat_program(-100, 16'h8000);
        mac_program(4, PACE_GAPS);
        // Illegal codes 11 and 15 travel as no-ops
        load_product(5);
        add_op(5, 1'b0, PACE_HIGH, make_instr(4'hB, 1'b0, 5), 1'b1);
        add_op(5, 1'b0, PACE_HIGH, make_instr(4'hF, 1'b1, -1), 1'b1);
        add_store(5, PACE_HIGH, make_instr(OP_STL, 1'b0, 0), 16'hF7CC, 1'b0, 1'b1);
        add_store(5, PACE_HIGH, make_instr(OP_STH, 1'b0, 0), 16'hFFFF, 1'b0, 1'b1);
        add_store(5, PACE_HIGH, make_instr(OP_STL, 1'b1, 0), 16'h0000, 1'b0, 1'b1);
        // p still holds -2100, and x * y still gives it, so a1 ends at -4200
        add_op(5, 1'b0, PACE_HIGH, make_instr(OP_LDP, 1'b1, 0), 1'b1);
        add_store(5, PACE_HIGH, make_instr(OP_STL, 1'b1, 0), 16'hF7CC, 1'b0, 1'b1);
        add_op(5, 1'b0, PACE_HIGH, make_instr(OP_MPY, 1'b0, 0), 1'b1);
        add_op(5, 1'b0, PACE_HIGH, make_instr(OP_MAC, 1'b1, 0), 1'b1);
        add_store(5, PACE_HIGH, make_instr(OP_STL, 1'b1, 0), 16'hEF98, 1'b0, 1'b1);
        add_op(5, 1'b1, PACE_HIGH, make_instr(OP_NOP, 1'b0, 0), 1'b0);
        add_store(5, PACE_HIGH, make_instr(OP_STL, 1'b0, 0), 16'h0000, 1'b0, 1'b0);
        // a1 = -2100 << 16 still lies inside 32 bits
        load_product(6);
        add_op(6, 1'b0, PACE_HIGH, make_instr(OP_LDP, 1'b1, 0), 1'b0);
        add_op(6, 1'b0, PACE_HIGH, make_instr(OP_SHL, 1'b1, 0), 1'b0);
        add_store(6, PACE_BURST, make_instr(OP_STL, 1'b0, 0), 16'hF7CC, 1'b0, 1'b0);
        add_store(6, PACE_BURST, make_instr(OP_STH, 1'b0, 0), 16'hFFFF, 1'b0, 1'b0);
        add_store(6, PACE_BURST, make_instr(OP_STL, 1'b1, 0), 16'h0000, 1'b0, 1'b0);
        add_store(6, PACE_HIGH, make_instr(OP_STH, 1'b1, 0), 16'hF7CC, 1'b0, 1'b0);
    endtask

    task automatic check_output();
        logic [DATA_W-1:0] exp_data;
        logic              exp_sat;
        int                latency;
        checks++;
        if (exp_data_q.size() == 0) begin
            $display("Error: out_valid strobe with no store pending at %0t", $time);
            errors++;
        end else begin
            exp_data = exp_data_q.pop_front();
            exp_sat  = exp_sat_q.pop_front();
            latency  = edge_cnt - exp_edge_q.pop_front();
            if (out_data !== exp_data) begin
                $display("Mismatch out_data: expected 0x%h, got 0x%h", exp_data, out_data);
                errors++;
            end
            if (out_sat !== exp_sat) begin
                $display("Mismatch out_sat: expected 0x%h, got 0x%h", exp_sat, out_sat);
                errors++;
            end
            if (latency != 2) begin
                $display("Error: store result came %0d enabled edges after acceptance", latency);
                errors++;
            end
        end
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        cen         = 1'b0;
        instr_valid = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        exp_data_q.delete();
        exp_sat_q.delete();
        exp_edge_q.delete();
    endtask

    // Random cen for the first cycles of the wait, then cen held high
    task automatic wait_for_stores(input int pace);
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_MAX) begin
            cen = (pace == PACE_GAPS && waited < 8) ? ($urandom_range(0, 1) == 1) : 1'b1;
            @(negedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("Error: no out_valid for a pending store within %0d cycles", DRAIN_MAX);
            errors++;
            exp_data_q.delete();
            exp_sat_q.delete();
            exp_edge_q.delete();
        end
    endtask

    task automatic apply_row(input row_t r);
        int gaps;
        if (r.rst) begin
            apply_reset();
        end
        if (r.pace == PACE_GAPS) begin
            gaps = $urandom_range(1, 3);
            repeat (gaps) begin
                // Offered while cen is low, so it must leave no trace
                cen         = 1'b0;
                instr_valid = 1'b1;
                instr       = 16'($urandom);
                @(negedge clk);
            end
        end
        cen         = 1'b1;
        instr_valid = 1'b1;
        instr       = r.instr;
        if (r.store) begin
            exp_data_q.push_back(r.data);
            exp_sat_q.push_back(r.sat);
            exp_edge_q.push_back(edge_cnt + 1);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        checks++;
        if (fault !== r.fault) begin
            $display("Mismatch fault: expected 0x%h, got 0x%h", r.fault, fault);
            errors++;
        end
        if (r.store && r.pace != PACE_BURST) begin
            wait_for_stores(r.pace);
        end
    endtask

    task automatic finish_test(input int id, input int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d (%s): %s, %0d errors", id, test_name(id),
                 (errs == 0) ? "pass" : "fail", errs);
    endtask

    initial begin
        int prev_test;
        int err_base;
        rst_n         = 1'b0;
        cen           = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        edge_cnt      = 0;
        last_out_edge = -1;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        void'($urandom(38906));
        build_table();
        table_len = rows.size();
        prev_test = rows[0].test;
        err_base  = 0;
        @(negedge clk);
        for (int i = 0; i < table_len; i++) begin
            if (rows[i].test != prev_test) begin
                finish_test(prev_test, errors - err_base);
                prev_test = rows[i].test;
                err_base  = errors;
            end
            apply_row(rows[i]);
        end
        finish_test(prev_test, errors - err_base);
        $display("Done: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Budget of 20 cycles per table row
    initial begin
        wait (table_len > 0);
        #(table_len * 20 * CLK_PERIOD);
        $display("Error: watchdog expired before the table finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- compile.f
hw/dsp_pkg.sv
hw/dsp_if.sv
hw/dsp_decode.sv
hw/dsp_dau.sv
hw/dsp_result.sv
hw/dsp_core.sv
tests/tb_dsp_core.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_dsp_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
